// ==== sim.f ====
+incdir+rtl
rtl/axisMonPkg.sv
rtl/handshakeChecker.sv
rtl/readyWaitTimer.sv
rtl/streamStatistics.sv
rtl/violationRecorder.sv
rtl/axisMonitor.sv
tests/axisMonitor_assert.sv
tests/axisMonitorTb.sv

// ==== Makefile ====
# Verilator flow for the AXI4-Stream monitor testbench

LOG = sim.log

all: run

# build, run, then decide on the pass line in the log
run:
	verilator --binary --timing --assert -f sim.f --top-module axisMonitorTb -Mdir obj_dir -o axisMonitorTb
	./obj_dir/axisMonitorTb +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

# lint of the design alone
lint:
	verilator --lint-only -Wall +incdir+rtl --top-module axisMonitor \
		rtl/axisMonPkg.sv rtl/handshakeChecker.sv rtl/readyWaitTimer.sv \
		rtl/streamStatistics.sv rtl/violationRecorder.sv rtl/axisMonitor.sv

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean

// ==== tests/axisMonitorTb.sv ====
// testbench of the AXI4-Stream monitor with clock, reset, stimulus tasks, value checks and report
`timescale 1ns/1ns
`include "axisMon_settings.svh"

module axisMonitorTb
   import axisMonPkg::*;
();

   logic         ACLK = 1'b0;      // low from the start, first edge is a rising one
   logic         RESET_CHECKS;
   axisPayload_t payload;
   logic         TVALID;
   logic         TREADY;
   logic         clearReq;
   violation_t   violations;
   statistics_t  statistics;
   logic         clearAck;

   logic [31:0]  lcgState;         // random state
   int           errorCount;       // failed checks so far
   int           testCount;
   int           failedTests;
   int           testStartErrors;  // errorCount when the running test began
   int unsigned  expBytes;         // expected data-byte count
   violation_t   expFlags;
   axisPayload_t word;

   axisMonitor axisMonitor_i (
      .ACLK         (ACLK),
      .RESET_CHECKS (RESET_CHECKS),
      .payload      (payload),
      .TVALID       (TVALID),
      .TREADY       (TREADY),
      .clearReq     (clearReq),
      .violations   (violations),
      .statistics   (statistics),
      .clearAck     (clearAck)
   );

   initial begin
      forever #20 ACLK = ~ACLK;    // 40 ns period
   end

   // linear congruential generator, upper bits are the useful ones
   function automatic logic [31:0] nextRandom();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // legal word, KEEP equals STRB so no position or reserved bytes
   function automatic axisPayload_t randomPayload();
      axisPayload_t pw;
      logic [31:0]  rnd;
      rnd = nextRandom();
      pw.data = `AXIS_DATA_WIDTH'(rnd);
      rnd = nextRandom();
      pw.keep = axisStrb_t'(rnd[31:28]);
      pw.strb = pw.keep;
      pw.last = 1'b0;
      pw.id = `AXIS_ID_WIDTH'(rnd[23:16]);
      pw.dest = `AXIS_DEST_WIDTH'(rnd[15:8]);
      pw.user = `AXIS_USER_WIDTH'(rnd[7:0]);
      return pw;
   endfunction

   task automatic checkValue(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
      assert (got === expected)
      else begin
         $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, expected);
         errorCount++;
      end
   endtask

   task automatic checkFlags(input violation_t expected);
      checkValue("violations", 64'(violations), 64'(expected));
   endtask

   // 8 reset edges, TVALID may be raised for the last one
   task automatic applyReset(input logic validLate);
      RESET_CHECKS = 1'b1;
      TVALID = 1'b0;
      TREADY = 1'b0;
      repeat (7) @(negedge ACLK);
      TVALID = validLate;
      @(negedge ACLK);
      RESET_CHECKS = 1'b0;
      TVALID = 1'b0;
      @(negedge ACLK);             // first edge out of reset has been judged
   endtask

   // one transfer with a given number of stall edges, then one idle cycle
   task automatic sendTransfer(input axisPayload_t pw, input int stallCycles);
      payload = pw;
      TVALID = 1'b1;
      TREADY = 1'b0;
      repeat (stallCycles) @(negedge ACLK);
      TREADY = 1'b1;
      @(negedge ACLK);             // handshake edge passed
      TVALID = 1'b0;
      TREADY = 1'b0;
      @(negedge ACLK);
   endtask

   task automatic waitForAck(input logic level);
      int cycles;
      cycles = 0;
      while (clearAck !== level && cycles < 10) begin
         @(negedge ACLK);
         cycles++;
      end
      if (clearAck !== level) begin
         $display("timeout: clearAck did not go to %0d within 10 cycles", level);
         errorCount++;
      end
   endtask

   // four-phase clear from the host side
   task automatic clearFlags();
      clearReq = 1'b1;
      waitForAck(1'b1);
      clearReq = 1'b0;
      waitForAck(1'b0);
   endtask

   task automatic endTest(input string name);
      testCount++;
      if (errorCount == testStartErrors) begin
         $display("test %0d %s: ok", testCount, name);
      end else begin
         failedTests++;
         $display("test %0d %s: %0d checks failed", testCount, name,
                  errorCount - testStartErrors);
      end
      testStartErrors = errorCount;
   endtask

   initial begin
      lcgState = 32'd35183;
      errorCount = 0;
      testCount = 0;
      failedTests = 0;
      testStartErrors = 0;
      RESET_CHECKS = 1'b1;
      payload = '0;
      TVALID = 1'b0;
      TREADY = 1'b0;
      clearReq = 1'b0;
      applyReset(1'b0);

      // clean traffic, stalls stay below the wait limit
      expBytes = 0;
      for (int i = 0; i < 20; i++) begin
         word = randomPayload();
         word.last = (i % 5 == 4);                 // every fifth closes a packet
         expBytes = expBytes + $countones(word.keep & word.strb);
         sendTransfer(word, int'(nextRandom() >> 16) % `AXIS_MAX_WAITS);
      end
      checkFlags('0);
      checkValue("statistics.transfers", 64'(statistics.transfers), 64'(20));
      checkValue("statistics.packets", 64'(statistics.packets), 64'(4));
      checkValue("statistics.dataBytes", 64'(statistics.dataBytes), 64'(expBytes));
      endTest("clean traffic");

      // TVALID dropped while stalled
      clearFlags();
      word = randomPayload();
      payload = word;
      TVALID = 1'b1;
      TREADY = 1'b0;
      repeat (3) @(negedge ACLK);
      TVALID = 1'b0;
      @(negedge ACLK);
      expFlags = '0;
      expFlags.validDropped = 1'b1;
      checkFlags(expFlags);
      // data moved while stalled
      clearFlags();
      payload = word;
      TVALID = 1'b1;
      repeat (2) @(negedge ACLK);
      payload.data = payload.data ^ `AXIS_DATA_WIDTH'(nextRandom() | 32'd1);
      @(negedge ACLK);
      TREADY = 1'b1;
      @(negedge ACLK);
      TVALID = 1'b0;
      TREADY = 1'b0;
      @(negedge ACLK);
      expFlags = '0;
      expFlags.payloadChanged = 1'b1;
      checkFlags(expFlags);
      endTest("handshake rules");

      // byte 0 with KEEP low and STRB high is reserved
      clearFlags();
      word = randomPayload();
      word.keep = '1;
      word.keep[0] = 1'b0;
      word.strb = '1;
      sendTransfer(word, 1);
      expFlags = '0;
      expFlags.reservedStrobe = 1'b1;
      checkFlags(expFlags);
      clearFlags();
      word.keep = '1;              // position bytes are legal
      word.strb = '0;
      word.strb[0] = 1'b1;
      sendTransfer(word, 1);
      checkFlags('0);
      endTest("reserved strobe");

      clearFlags();
      word = randomPayload();
      sendTransfer(word, 5);
      checkFlags('0);
      sendTransfer(word, 20);      // beyond AXIS_MAX_WAITS
      expFlags = '0;
      expFlags.readyTimeout = 1'b1;
      checkFlags(expFlags);
      endTest("ready wait");

      applyReset(1'b1);
      expFlags = '0;
      expFlags.validInReset = 1'b1;
      checkFlags(expFlags);
      applyReset(1'b0);
      checkFlags('0);
      checkValue("statistics", 64'(statistics), 64'(0));
      endTest("reset rule");

      // make flags and counters non-zero first
      word = randomPayload();
      word.keep = '0;
      word.strb = '0;
      word.strb[0] = 1'b1;
      sendTransfer(word, 2);
      word = randomPayload();
      word.last = 1'b1;
      sendTransfer(word, 0);
      checkValue("statistics.transfers", 64'(statistics.transfers), 64'(2));
      checkValue("statistics.packets", 64'(statistics.packets), 64'(1));
      expFlags = '0;
      expFlags.reservedStrobe = 1'b1;
      checkFlags(expFlags);
      clearFlags();
      checkFlags('0);
      checkValue("statistics", 64'(statistics), 64'(0));
      checkValue("clearAck", 64'(clearAck), 64'(0));
      endTest("clear handshake");

      // bound assertion failures count as failed checks too
      errorCount = errorCount + int'(axisMonitor_i.axisMonitorChecks_i.failCount);
      $display("tests run %0d, tests failed %0d, checks failed %0d",
               testCount, failedTests, errorCount);
      if (errorCount == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== tests/axisMonitor_assert.sv ====
// bound concurrent checks on the clear handshake, sticky flags and reset values of the monitor
`timescale 1ns/1ns

module axisMonitorChecks
   import axisMonPkg::*;
(
   input logic        ACLK,
   input logic        RESET_CHECKS,
   input logic        clearReq,
   input logic        clearAck,
   input violation_t  violations,
   input statistics_t statistics
);

   logic [$bits(violation_t)-1:0]  flagBits;     // flags as a plain vector
   logic [$bits(statistics_t)-1:0] statBits;     // counters as a plain vector
   logic                           clearEdge;    // request seen, not yet acknowledged
   int unsigned                    failCount = 0; // read by the testbench at the end

   assign flagBits = violations;
   assign statBits = statistics;
   assign clearEdge = clearReq & ~clearAck;

   // phase 2 needs a pending request
   ackRiseNeedsReq: assert property (@(posedge ACLK) disable iff (RESET_CHECKS)
      (!clearAck && !clearReq) |=> !clearAck)
      else begin
         $error("clearAck rose while clearReq was low");
         failCount++;
      end

   // phase 4 only once the host let go
   ackHoldsWithReq: assert property (@(posedge ACLK) disable iff (RESET_CHECKS)
      (clearAck && clearReq) |=> clearAck)
      else begin
         $error("clearAck fell while clearReq was still high");
         failCount++;
      end

   // sticky flags, a bit may only drop on the clearing edge
   flagsStayUp: assert property (@(posedge ACLK) disable iff (RESET_CHECKS)
      !clearEdge |=> ((flagBits & $past(flagBits)) == $past(flagBits)))
      else begin
         $error("a violation flag fell outside a clearing edge");
         failCount++;
      end

   // every output register is zero right after a reset edge
   zeroAfterReset: assert property (@(posedge ACLK)
      RESET_CHECKS |=> (flagBits == '0 && statBits == '0 && !clearAck))
      else begin
         $error("outputs not zero after reset");
         failCount++;
      end

endmodule

bind axisMonitor axisMonitorChecks axisMonitorChecks_i (
   .ACLK         (ACLK),
   .RESET_CHECKS (RESET_CHECKS),
   .clearReq     (clearReq),
   .clearAck     (clearAck),
   .violations   (violations),
   .statistics   (statistics)
);

// ==== rtl/axisMonitor.sv ====
// top level of the passive AXI4-Stream monitor with checkers, timer, counters and recorder
`timescale 1ns/1ns

module axisMonitor
   import axisMonPkg::*;
(
   input  logic         ACLK,
   input  logic         RESET_CHECKS,   // synchronous, active high
   input  axisPayload_t payload,        // TDATA, TSTRB, TKEEP, TLAST, TID, TDEST, TUSER
   input  logic         TVALID,
   input  logic         TREADY,
   input  logic         clearReq,
   output violation_t   violations,     // sticky rule flags
   output statistics_t  statistics,     // traffic counters
   output logic         clearAck
);

   logic       validDropped;    // from handshakeChecker
   logic       payloadChanged;  // from handshakeChecker
   logic       readyTimeout;    // from readyWaitTimer
   logic       reservedStrobe;  // from streamStatistics
   logic       clearPulse;      // recorder to counters
   violation_t events;          // merged pulses, reset rule lives in the recorder

   handshakeChecker handshakeChecker_i (
      .ACLK           (ACLK),
      .RESET_CHECKS   (RESET_CHECKS),
      .payload        (payload),
      .TVALID         (TVALID),
      .TREADY         (TREADY),
      .validDropped   (validDropped),
      .payloadChanged (payloadChanged)
   );

   readyWaitTimer readyWaitTimer_i (
      .ACLK         (ACLK),
      .RESET_CHECKS (RESET_CHECKS),
      .TVALID       (TVALID),
      .TREADY       (TREADY),
      .readyTimeout (readyTimeout)
   );

   streamStatistics streamStatistics_i (
      .ACLK           (ACLK),
      .RESET_CHECKS   (RESET_CHECKS),
      .payload        (payload),
      .TVALID         (TVALID),
      .TREADY         (TREADY),
      .clearPulse     (clearPulse),
      .reservedStrobe (reservedStrobe),
      .statistics     (statistics)
   );

   assign events = '{validDropped: validDropped, payloadChanged: payloadChanged,
                     reservedStrobe: reservedStrobe, readyTimeout: readyTimeout,
                     validInReset: 1'b0};

   violationRecorder violationRecorder_i (
      .ACLK         (ACLK),
      .RESET_CHECKS (RESET_CHECKS),
      .TVALID       (TVALID),
      .events       (events),
      .clearReq     (clearReq),
      .clearAck     (clearAck),
      .clearPulse   (clearPulse),
      .violations   (violations)
   );

endmodule

// ==== rtl/violationRecorder.sv ====
// reset rule check, sticky violation flags and the four-phase clear handshake
`timescale 1ns/1ns

module violationRecorder
   import axisMonPkg::*;
(
   input  logic       ACLK,
   input  logic       RESET_CHECKS,   // synchronous, active high
   input  logic       TVALID,
   input  violation_t events,         // one-cycle pulses from the checkers
   input  logic       clearReq,       // host side of the clear handshake
   output logic       clearAck,
   output logic       clearPulse,     // clearing edge, also zeroes the counters
   output violation_t violations      // sticky flags
);

   logic       resetSeen;     // RESET_CHECKS at the previous edge
   logic       validSeen;     // TVALID at the previous edge
   logic       firstEdge;     // first edge after reset went low
   logic       resetRuleHit;  // TVALID broke the reset rule
   violation_t eventsAll;     // checker pulses plus the reset rule
   violation_t flagsKept;     // flags surviving a clear

   // previous-edge samples of reset and TVALID for the reset rule
   always_ff @(posedge ACLK) begin
      resetSeen <= RESET_CHECKS;
      validSeen <= TVALID;
   end

   assign firstEdge = resetSeen & ~RESET_CHECKS;

   // TVALID at the last reset edge or at the first edge out of reset
   assign resetRuleHit = firstEdge & (validSeen | TVALID);

   always_comb begin
      eventsAll = events;
      eventsAll.validInReset = events.validInReset | resetRuleHit;
   end

   // step 2 of the handshake, request seen and not yet acknowledged
   assign clearPulse = clearReq & ~clearAck;

   assign flagsKept = clearPulse ? '0 : violations;

   always_ff @(posedge ACLK) begin
      if (RESET_CHECKS) begin
         violations <= '0;
         clearAck   <= 1'b0;
      end else begin
         // set wins over clear, events on the clearing edge stay recorded
         violations <= flagsKept | eventsAll;
         if (clearPulse) begin
            clearAck <= 1'b1;               // acknowledge with flags cleared
         end else if (!clearReq) begin
            clearAck <= 1'b0;               // step 4, host dropped the request
         end
      end
   end

   // a held clearReq keeps clearAck high and clears nothing more
   // the monitor never stalls the host, each phase takes one edge

endmodule

// ==== rtl/streamStatistics.sv ====
// reserved TKEEP/TSTRB check with transfer, packet and data-byte counters
`timescale 1ns/1ns
`include "axisMon_settings.svh"

module streamStatistics
   import axisMonPkg::*;
(
   input  logic         ACLK,
   input  logic         RESET_CHECKS,    // synchronous, active high
   input  axisPayload_t payload,
   input  logic         TVALID,
   input  logic         TREADY,
   input  logic         clearPulse,      // zero the counters on this edge
   output logic         reservedStrobe,  // one-cycle event pulse
   output statistics_t  statistics       // wrapping counters
);

   logic        handshake;    // transfer accepted this edge
   axisStrb_t   reservedMask; // lanes with KEEP low and STRB high
   axisStrb_t   dataMask;     // lanes carrying a real data byte
   statistics_t statsBase;    // counters after an optional clear
   statistics_t statsNext;    // counters for the next edge

   // number of set lanes, widened to counter size
   function automatic logic [`AXIS_COUNT_WIDTH-1:0] laneCount(input axisStrb_t mask);
      logic [`AXIS_COUNT_WIDTH-1:0] total;
      total = '0;
      for (int lane = 0; lane < `AXIS_DATA_BYTES; lane++) begin
         total = total + `AXIS_COUNT_WIDTH'(mask[lane]);
      end
      return total;
   endfunction

   assign handshake = TVALID & TREADY;
   assign reservedMask = ~payload.keep & payload.strb;
   assign dataMask = payload.keep & payload.strb;     // position and null bytes drop out

   // KEEP low STRB high is the reserved combination, judged whenever TVALID is up
   assign reservedStrobe = TVALID & (|reservedMask);

   // a clear and a handshake on the same edge leave just that one transfer counted
   always_comb begin
      statsBase = clearPulse ? '0 : statistics;
      statsNext = statsBase;
      if (handshake) begin
         statsNext.transfers = statsBase.transfers + `AXIS_COUNT_WIDTH'(1);
         statsNext.packets = statsBase.packets + `AXIS_COUNT_WIDTH'(payload.last);
         statsNext.dataBytes = statsBase.dataBytes + laneCount(dataMask);
      end
   end

   always_ff @(posedge ACLK) begin
      if (RESET_CHECKS) begin
         statistics <= '0;
      end else begin
         statistics <= statsNext;        // wraps silently at full count
      end
   end

endmodule

// ==== rtl/readyWaitTimer.sv ====
// TREADY wait timer, flags a stall run longer than AXIS_MAX_WAITS cycles
`timescale 1ns/1ns
`include "axisMon_settings.svh"

module readyWaitTimer (
   input  logic ACLK,
   input  logic RESET_CHECKS,   // synchronous, active high
   input  logic TVALID,
   input  logic TREADY,
   output logic readyTimeout    // one pulse per over-long stall run
);

   logic                        stall;       // TVALID waiting on TREADY this edge
   logic [`AXIS_WAIT_WIDTH-1:0] stallCount;  // stall edges seen before this one
   logic                        countFull;   // saturated, run already flagged

   assign stall = TVALID & ~TREADY;
   assign countFull = (stallCount == `AXIS_WAIT_WIDTH'(`AXIS_MAX_WAITS + 1));

   // counts consecutive stall edges, any non-stall edge restarts it
   always_ff @(posedge ACLK) begin
      if (RESET_CHECKS) begin
         stallCount <= '0;
      end else if (!stall) begin
         stallCount <= '0;                              // handshake or idle ends the run
      end else if (!countFull) begin
         stallCount <= stallCount + `AXIS_WAIT_WIDTH'(1);
      end
   end

   // fires on the (AXIS_MAX_WAITS+1)th stall edge in a row
   // after that the counter sits at full and the pulse stays low
   assign readyTimeout = stall & (stallCount == `AXIS_WAIT_WIDTH'(`AXIS_MAX_WAITS));

endmodule

// ==== rtl/handshakeChecker.sv ====
// handshake rule checker for dropped TVALID and unstable payload during a stall
`timescale 1ns/1ns

module handshakeChecker
   import axisMonPkg::*;
(
   input  logic         ACLK,
   input  logic         RESET_CHECKS,     // synchronous, active high
   input  axisPayload_t payload,          // observed payload of the link
   input  logic         TVALID,
   input  logic         TREADY,
   output logic         validDropped,     // one-cycle event pulse
   output logic         payloadChanged    // one-cycle event pulse
);

   logic         waiting;      // previous edge saw TVALID without TREADY
   logic         payloadDiff;  // payload differs from the copy
   axisPayload_t payloadQ;     // payload as sampled at the previous edge

   // a transfer is pending from the edge where TVALID is seen without TREADY
   // until the edge where both are high
   always_ff @(posedge ACLK) begin
      if (RESET_CHECKS) begin
         waiting <= 1'b0;                 // no pending transfer out of reset
      end else begin
         waiting <= TVALID & ~TREADY;     // stall sampled, rules apply next edge
      end
   end

   // copy of the payload for the stability compare
   always_ff @(posedge ACLK) begin
      payloadQ <= payload;
   end

   // whole struct compare covers TDATA, TSTRB, TKEEP, TLAST, TID, TDEST, TUSER
   assign payloadDiff = (payload != payloadQ);

   // pending transfer lost its TVALID before TREADY came
   assign validDropped = waiting & ~TVALID;

   // TVALID still up but the source moved data or control
   // a change at the handshake edge itself also counts, the value was not yet taken
   assign payloadChanged = waiting & TVALID & payloadDiff;

   // one copy of the payload per edge keeps the compare exact to the cycle,
   // a single changed field in any of the seven signals is enough
   // both pulses depend on the pending bit, so a clean idle link never fires them

endmodule

// ==== rtl/axisMonPkg.sv ====
// payload, violation flag and statistics counter types of the AXI4-Stream monitor
`include "axisMon_settings.svh"

package axisMonPkg;

   // one bit per byte lane
   typedef logic [`AXIS_DATA_BYTES-1:0] axisStrb_t;

   // everything the source must hold stable while a transfer waits
   typedef struct packed {
      logic [`AXIS_DATA_WIDTH-1:0] data;   // TDATA
      axisStrb_t                   strb;   // TSTRB, byte is data (1) or position (0)
      axisStrb_t                   keep;   // TKEEP, byte is kept (1) or null (0)
      logic                        last;   // TLAST, packet boundary
      logic [`AXIS_ID_WIDTH-1:0]   id;     // TID
      logic [`AXIS_DEST_WIDTH-1:0] dest;   // TDEST routing
      logic [`AXIS_USER_WIDTH-1:0] user;   // TUSER sideband
   } axisPayload_t;

   // rule flags, used both as one-cycle events and as sticky outputs
   typedef struct packed {
      logic validDropped;     // TVALID fell before its handshake
      logic payloadChanged;   // payload moved while the transfer waited
      logic reservedStrobe;   // KEEP low with STRB high on some byte
      logic readyTimeout;     // TREADY missing for more than AXIS_MAX_WAITS cycles
      logic validInReset;     // TVALID high in reset or on the first edge out of it
   } violation_t;

   // traffic counters, all wrap
   typedef struct packed {
      logic [`AXIS_COUNT_WIDTH-1:0] transfers;   // TVALID and TREADY handshakes
      logic [`AXIS_COUNT_WIDTH-1:0] packets;     // handshakes with TLAST
      logic [`AXIS_COUNT_WIDTH-1:0] dataBytes;   // bytes with KEEP and STRB both set
   } statistics_t;

endpackage

// ==== rtl/axisMon_settings.svh ====
// width and limit macros of the AXI4-Stream monitor
`ifndef AXISMON_SETTINGS_SVH
`define AXISMON_SETTINGS_SVH

// stream geometry
`define AXIS_DATA_BYTES 4                          // TDATA width in bytes
`define AXIS_DATA_WIDTH (8 * `AXIS_DATA_BYTES)     // TDATA width in bits
`define AXIS_ID_WIDTH 8                            // TID, 8 is the recommended maximum
`define AXIS_DEST_WIDTH 4                          // TDEST, 4 is the recommended maximum
`define AXIS_USER_WIDTH 4                          // TUSER sideband

// TREADY wait rule
// a stall is TVALID high with TREADY low, the rule tolerates this many in a row
`define AXIS_MAX_WAITS 16
// stall counter runs up to AXIS_MAX_WAITS + 1 and then saturates
`define AXIS_WAIT_WIDTH ($clog2(`AXIS_MAX_WAITS + 2))

// statistics
`define AXIS_COUNT_WIDTH 16                        // each counter wraps at this width

`endif
